// ==== rtl/rbm_pkg.sv ====
package rbm_pkg;

   // word widths
   parameter int weight_width = 12;
   parameter int acc_width    = 14;
   parameter int prob_width   = 8;

   // accumulator clamps symmetrically at this magnitude
   parameter int acc_max = 8191;

   // piecewise-linear sigmoid: (acc >>> sig_shift) + prob_half, clamped to 0..255
   parameter int sig_shift = 5;
   parameter int prob_half = 128;

   // Galois LFSR, x^8+x^6+x^5+x^4+1, right-shifting form
   parameter logic [prob_width-1:0] lfsr_taps = 8'hb8;

   // layer sequencer
   typedef enum logic [2:0] {
      idle,
      bias_req,
      bias_wait,
      weight_req,
      weight_wait,
      decide,
      hold
   } layer_state_e;

   // owner of the weight store for one cycle
   typedef enum logic [1:0] {
      none,
      load,
      fwd,
      bwd
   } grant_e;

   typedef enum logic {
      mode_mean,
      mode_sample
   } neuron_mode_e;

endpackage

// ==== rtl/weight_bus_if.sv ====
`timescale 1ns/10ps

interface weight_bus_if #(
   parameter int addr_width = 8
);

   logic                                   req_valid;
   logic                                   req_ready;
   logic [addr_width-1:0]                  req_addr;
   logic                                   req_we;
   logic signed [rbm_pkg::weight_width-1:0] req_wdata;
   logic                                   rsp_valid;
   logic signed [rbm_pkg::weight_width-1:0] rsp_data;

   // write fields are only driven on the arbiter-to-store link
   modport client (
      output req_valid, req_addr, req_we, req_wdata,
      input  req_ready, rsp_valid, rsp_data
   );

   modport arbiter (
      input  req_valid, req_addr,
      output req_ready, rsp_valid, rsp_data
   );

   // store has no back-pressure and no response strobe
   modport memory (
      input  req_valid, req_we, req_addr, req_wdata,
      output rsp_data
   );

endinterface

// ==== rtl/weight_store.sv ====
`timescale 1ns/10ps

module weight_store #(
   parameter int addr_width = 8
) (
   input logic          clock,
   weight_bus_if.memory bus
);

   localparam int depth = 2 ** addr_width;

   // weights first, then hidden biases, then visible biases
   logic signed [rbm_pkg::weight_width-1:0] mem [depth];

   // one access per cycle, write or registered read
   always_ff @(posedge clock) begin
      if (bus.req_valid) begin
         if (bus.req_we) begin
            mem[bus.req_addr] <= bus.req_wdata;
         end else begin
            bus.rsp_data <= mem[bus.req_addr];
         end
      end
   end

   // every granted access must carry a resolved address
   a_addr_known : assert property (
      @(posedge clock)
      bus.req_valid |-> !$isunknown(bus.req_addr)
   );

   // write data from the load port must be resolved
   a_wdata_known : assert property (
      @(posedge clock)
      bus.req_valid && bus.req_we |-> !$isunknown(bus.req_wdata)
   );

endmodule

// ==== rtl/weight_arbiter.sv ====
`timescale 1ns/10ps

module weight_arbiter #(
   parameter int addr_width = 8
) (
   input  logic                                   clock,
   input  logic                                   reset,
   input  logic                                   load_valid,
   input  logic [addr_width-1:0]                  load_addr,
   input  logic signed [rbm_pkg::weight_width-1:0] load_data,
   output logic                                   load_ready,
   weight_bus_if.arbiter                          fwd_bus,
   weight_bus_if.arbiter                          bwd_bus,
   weight_bus_if.client                           mem_bus
);

   rbm_pkg::grant_e grant;
   rbm_pkg::grant_e rsp_owner;
   // fwd took the last contested or uncontested layer grant
   logic last_fwd;

   // load writes always win, layers alternate under contention
   always_comb begin
      if (load_valid) begin
         grant = rbm_pkg::load;
      end else if (fwd_bus.req_valid && bwd_bus.req_valid) begin
         if (last_fwd) begin
            grant = rbm_pkg::bwd;
         end else begin
            grant = rbm_pkg::fwd;
         end
      end else if (fwd_bus.req_valid) begin
         grant = rbm_pkg::fwd;
      end else if (bwd_bus.req_valid) begin
         grant = rbm_pkg::bwd;
      end else begin
         grant = rbm_pkg::none;
      end
   end

   // load port idles ready when nobody else holds the store
   assign load_ready      = (grant == rbm_pkg::load) || (grant == rbm_pkg::none);
   assign fwd_bus.req_ready = (grant == rbm_pkg::fwd);
   assign bwd_bus.req_ready = (grant == rbm_pkg::bwd);

   always_comb begin
      mem_bus.req_valid = (grant != rbm_pkg::none);
      mem_bus.req_we    = (grant == rbm_pkg::load);
      mem_bus.req_wdata = load_data;
      case (grant)
         rbm_pkg::fwd: mem_bus.req_addr = fwd_bus.req_addr;
         rbm_pkg::bwd: mem_bus.req_addr = bwd_bus.req_addr;
         default:      mem_bus.req_addr = load_addr;
      endcase
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         rsp_owner <= rbm_pkg::none;
         last_fwd  <= 1'b0;
      end else begin
         // only reads produce a response
         if (grant == rbm_pkg::fwd || grant == rbm_pkg::bwd) begin
            rsp_owner <= grant;
            last_fwd  <= (grant == rbm_pkg::fwd);
         end else begin
            rsp_owner <= rbm_pkg::none;
         end
      end
   end

   // store data goes to both, strobe only to the owner
   assign fwd_bus.rsp_valid = (rsp_owner == rbm_pkg::fwd);
   assign bwd_bus.rsp_valid = (rsp_owner == rbm_pkg::bwd);
   assign fwd_bus.rsp_data  = mem_bus.rsp_data;
   assign bwd_bus.rsp_data  = mem_bus.rsp_data;

   // a granted client gets its response and does not ask again meanwhile
   a_fwd_one_outstanding : assert property (
      @(posedge clock) disable iff (reset)
      fwd_bus.req_valid && fwd_bus.req_ready |=> fwd_bus.rsp_valid && !fwd_bus.req_valid
   );

   a_bwd_one_outstanding : assert property (
      @(posedge clock) disable iff (reset)
      bwd_bus.req_valid && bwd_bus.req_ready |=> bwd_bus.rsp_valid && !bwd_bus.req_valid
   );

endmodule

// ==== rtl/neuron_unit.sv ====
`timescale 1ns/10ps

module neuron_unit (
   input  logic                                   clock,
   input  logic                                   reset,
   input  logic                                   clear,
   input  logic                                   add_valid,
   input  logic signed [rbm_pkg::weight_width-1:0] add_data,
   input  rbm_pkg::neuron_mode_e                  mode,
   input  logic [rbm_pkg::prob_width-1:0]         rand_value,
   output logic signed [rbm_pkg::acc_width-1:0]   acc,
   output logic                                   decision
);

   localparam int aw = rbm_pkg::acc_width;
   localparam int ww = rbm_pkg::weight_width;
   localparam int pw = rbm_pkg::prob_width;

   // one guard bit above the accumulator for overflow detection
   localparam logic signed [aw:0] sat_hi   = (aw+1)'(rbm_pkg::acc_max);
   localparam logic signed [aw:0] sat_lo   = -sat_hi;
   localparam logic signed [aw:0] prob_mid = (aw+1)'(rbm_pkg::prob_half);
   localparam logic signed [aw:0] prob_top = (aw+1)'((2 ** pw) - 1);
   localparam logic [pw-1:0]      half_level = pw'(rbm_pkg::prob_half);

   logic signed [aw:0] acc_ext;
   logic signed [aw:0] add_ext;
   logic signed [aw:0] sum;
   logic signed [aw:0] sat_sum;
   logic signed [aw:0] prob_raw;
   logic [pw-1:0]      prob;

   // saturating add
   always_comb begin
      acc_ext = {acc[aw-1], acc};
      add_ext = {{(aw+1-ww){add_data[ww-1]}}, add_data};
      sum     = acc_ext + add_ext;
      if (sum > sat_hi) begin
         sat_sum = sat_hi;
      end else if (sum < sat_lo) begin
         sat_sum = sat_lo;
      end else begin
         sat_sum = sum;
      end
   end

   // bias load on clear, then one weight per add_valid
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         acc <= '0;
      end else if (clear) begin
         acc <= {{(aw-ww){add_data[ww-1]}}, add_data};
      end else if (add_valid) begin
         acc <= sat_sum[aw-1:0];
      end
   end

   // sigmoid approximation
   always_comb begin
      prob_raw = (acc_ext >>> rbm_pkg::sig_shift) + prob_mid;
      if (prob_raw < 0) begin
         prob = '0;
      end else if (prob_raw > prob_top) begin
         prob = '1;
      end else begin
         prob = prob_raw[pw-1:0];
      end
   end

   assign decision = (mode == rbm_pkg::mode_mean) ? (prob > half_level) : (prob > rand_value);

   a_acc_bounded : assert property (
      @(posedge clock) disable iff (reset)
      (acc_ext <= sat_hi) && (acc_ext >= sat_lo)
   );

endmodule

// ==== rtl/rbm_layer.sv ====
`timescale 1ns/10ps

module rbm_layer #(
   parameter int                            in_dim     = 16,
   parameter int                            out_dim    = 8,
   parameter int                            addr_width = 8,
   parameter logic [rbm_pkg::prob_width-1:0] seed       = 8'h5a,
   parameter bit                            transposed = 1'b0,
   parameter int                            bias_base  = 128
) (
   input  logic                  clock,
   input  logic                  reset,
   input  rbm_pkg::neuron_mode_e mode,
   input  logic                  in_valid,
   output logic                  in_ready,
   input  logic [in_dim-1:0]     in_bits,
   output logic [in_dim-1:0]     in_copy,
   output logic                  out_valid,
   input  logic                  out_ready,
   output logic [out_dim-1:0]    out_bits,
   weight_bus_if.client          bus
);

   localparam int iw = $clog2(in_dim);
   localparam int ow = $clog2(out_dim);

   rbm_pkg::layer_state_e state;
   logic [in_dim-1:0]               in_reg;
   // active inputs not yet added for the current neuron
   logic [in_dim-1:0]               remain;
   logic [in_dim-1:0]               rest;
   logic [iw-1:0]                   cur;
   logic [ow-1:0]                   neuron;
   logic [out_dim-1:0]              out_reg;
   logic [rbm_pkg::prob_width-1:0]  lfsr;
   logic [rbm_pkg::prob_width-1:0]  lfsr_next;
   logic [addr_width-1:0]           bias_addr;
   logic [addr_width-1:0]           weight_addr;
   logic                            clear;
   logic                            add_valid;
   logic                            decision;

   function automatic logic [iw-1:0] lowest_set(input logic [in_dim-1:0] bits);
      lowest_set = '0;
      // scan down so the lowest set bit is the last one kept
      for (int k = in_dim - 1; k >= 0; k--) begin
         if (bits[k]) begin
            lowest_set = iw'(k);
         end
      end
   endfunction

   always_comb begin
      cur       = lowest_set(remain);
      rest      = remain;
      rest[cur] = 1'b0;
   end

   // address layout: W[v][h] at v*hidden_dim+h, biases after the weights
   always_comb begin
      bias_addr = addr_width'(bias_base + int'(neuron));
      if (transposed) begin
         weight_addr = addr_width'(int'(neuron) * in_dim + int'(cur));
      end else begin
         weight_addr = addr_width'(int'(cur) * out_dim + int'(neuron));
      end
   end

   assign bus.req_valid = (state == rbm_pkg::bias_req) || (state == rbm_pkg::weight_req);
   assign bus.req_addr  = (state == rbm_pkg::bias_req) ? bias_addr : weight_addr;

   assign clear     = (state == rbm_pkg::bias_wait) && bus.rsp_valid;
   assign add_valid = (state == rbm_pkg::weight_wait) && bus.rsp_valid;

   assign lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ rbm_pkg::lfsr_taps) : (lfsr >> 1);

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state  <= rbm_pkg::idle;
         neuron <= '0;
         remain <= '0;
         lfsr   <= seed;
      end else begin
         case (state)
            rbm_pkg::idle: begin
               if (in_valid) begin
                  neuron <= '0;
                  state  <= rbm_pkg::bias_req;
               end
            end
            rbm_pkg::bias_req: begin
               if (bus.req_ready) begin
                  state <= rbm_pkg::bias_wait;
               end
            end
            rbm_pkg::bias_wait: begin
               if (bus.rsp_valid) begin
                  remain <= in_reg;
                  if (in_reg == '0) begin
                     state <= rbm_pkg::decide;
                  end else begin
                     state <= rbm_pkg::weight_req;
                  end
               end
            end
            rbm_pkg::weight_req: begin
               if (bus.req_ready) begin
                  state <= rbm_pkg::weight_wait;
               end
            end
            rbm_pkg::weight_wait: begin
               if (bus.rsp_valid) begin
                  remain <= rest;
                  if (rest == '0) begin
                     state <= rbm_pkg::decide;
                  end else begin
                     state <= rbm_pkg::weight_req;
                  end
               end
            end
            rbm_pkg::decide: begin
               // LFSR steps once per neuron in either mode
               lfsr <= lfsr_next;
               if (neuron == ow'(out_dim - 1)) begin
                  state <= rbm_pkg::hold;
               end else begin
                  neuron <= neuron + 1'b1;
                  state  <= rbm_pkg::bias_req;
               end
            end
            rbm_pkg::hold: begin
               if (out_ready) begin
                  state <= rbm_pkg::idle;
               end
            end
            default: state <= rbm_pkg::idle;
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (state == rbm_pkg::idle && in_valid) begin
         in_reg <= in_bits;
      end
      if (state == rbm_pkg::decide) begin
         out_reg[neuron] <= decision;
      end
   end

   neuron_unit u_neuron (
      .clock      (clock),
      .reset      (reset),
      .clear      (clear),
      .add_valid  (add_valid),
      .add_data   (bus.rsp_data),
      .mode       (mode),
      .rand_value (lfsr),
      .acc        (),
      .decision   (decision)
   );

   assign in_ready  = (state == rbm_pkg::idle);
   assign out_valid = (state == rbm_pkg::hold);
   assign out_bits  = out_reg;
   assign in_copy   = in_reg;

   a_out_held : assert property (
      @(posedge clock) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_bits) && $stable(in_copy)
   );

   a_req_stable : assert property (
      @(posedge clock) disable iff (reset)
      bus.req_valid && !bus.req_ready |=> bus.req_valid && $stable(bus.req_addr)
   );

endmodule

// ==== rtl/rbm_gibbs_top.sv ====
`timescale 1ns/10ps

module rbm_gibbs_top #(
   parameter int                            visible_dim = 16,
   parameter int                            hidden_dim  = 8,
   parameter int                            addr_width  = 8,
   parameter logic [rbm_pkg::prob_width-1:0] fwd_seed    = 8'h5a,
   parameter logic [rbm_pkg::prob_width-1:0] bwd_seed    = 8'hc3
) (
   input  logic                                   clock,
   input  logic                                   reset,
   input  rbm_pkg::neuron_mode_e                  mode,
   input  logic                                   load_valid,
   output logic                                   load_ready,
   input  logic [addr_width-1:0]                  load_addr,
   input  logic signed [rbm_pkg::weight_width-1:0] load_data,
   input  logic                                   in_valid,
   output logic                                   in_ready,
   input  logic [visible_dim-1:0]                 in_visible,
   output logic                                   out_valid,
   input  logic                                   out_ready,
   output logic [hidden_dim-1:0]                  out_hidden,
   output logic [visible_dim-1:0]                 out_recon
);

   // hidden biases follow the weight block, visible biases follow those
   localparam int hidden_bias_base  = visible_dim * hidden_dim;
   localparam int visible_bias_base = visible_dim * hidden_dim + hidden_dim;

   logic                  fwd_valid;
   logic                  fwd_ready;
   logic [hidden_dim-1:0] fwd_bits;

   weight_bus_if #(.addr_width(addr_width)) fwd_bus ();
   weight_bus_if #(.addr_width(addr_width)) bwd_bus ();
   weight_bus_if #(.addr_width(addr_width)) mem_bus ();

   weight_store #(.addr_width(addr_width)) u_store (
      .clock (clock),
      .bus   (mem_bus)
   );

   weight_arbiter #(.addr_width(addr_width)) u_arbiter (
      .clock      (clock),
      .reset      (reset),
      .load_valid (load_valid),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .load_ready (load_ready),
      .fwd_bus    (fwd_bus),
      .bwd_bus    (bwd_bus),
      .mem_bus    (mem_bus)
   );

   // visible to hidden
   rbm_layer #(
      .in_dim     (visible_dim),
      .out_dim    (hidden_dim),
      .addr_width (addr_width),
      .seed       (fwd_seed),
      .transposed (1'b0),
      .bias_base  (hidden_bias_base)
   ) u_fwd (
      .clock     (clock),
      .reset     (reset),
      .mode      (mode),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_bits   (in_visible),
      .in_copy   (),
      .out_valid (fwd_valid),
      .out_ready (fwd_ready),
      .out_bits  (fwd_bits),
      .bus       (fwd_bus)
   );

   // hidden to visible, its held input is the hidden vector it reconstructed from
   rbm_layer #(
      .in_dim     (hidden_dim),
      .out_dim    (visible_dim),
      .addr_width (addr_width),
      .seed       (bwd_seed),
      .transposed (1'b1),
      .bias_base  (visible_bias_base)
   ) u_bwd (
      .clock     (clock),
      .reset     (reset),
      .mode      (mode),
      .in_valid  (fwd_valid),
      .in_ready  (fwd_ready),
      .in_bits   (fwd_bits),
      .in_copy   (out_hidden),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_bits  (out_recon),
      .bus       (bwd_bus)
   );

endmodule

// ==== bench/rbm_tb.sv ====
`timescale 1ns/10ps

module rbm_tb;

   localparam int vis_dim    = 16;
   localparam int hid_dim    = 8;
   localparam int hbias_base = vis_dim * hid_dim;
   localparam int vbias_base = vis_dim * hid_dim + hid_dim;
   localparam int word_count = vis_dim * hid_dim + hid_dim + vis_dim;
   localparam logic [7:0] fwd_seed = 8'h5a;
   localparam logic [7:0] bwd_seed = 8'hc3;
   localparam int wait_limit   = 2000;
   localparam int stream_limit = 20000;

   logic                  clock;
   logic                  reset;
   rbm_pkg::neuron_mode_e mode;
   logic                  load_valid;
   logic                  load_ready;
   logic [7:0]            load_addr;
   logic signed [11:0]    load_data;
   logic                  in_valid;
   logic                  in_ready;
   logic [15:0]           in_visible;
   logic                  out_valid;
   logic                  out_ready;
   logic [7:0]            out_hidden;
   logic [15:0]           out_recon;

   // reference copy of the store and of both LFSRs
   logic signed [11:0] mem_model [0:255];
   logic [7:0]         fwd_lfsr;
   logic [7:0]         bwd_lfsr;
   integer             seed = 32'hc5ce;
   int                 checks = 0;
   int                 errors = 0;
   int                 timeouts = 0;

   rbm_gibbs_top #(
      .visible_dim (vis_dim),
      .hidden_dim  (hid_dim),
      .addr_width  (8),
      .fwd_seed    (fwd_seed),
      .bwd_seed    (bwd_seed)
   ) DUT (
      .clock      (clock),
      .reset      (reset),
      .mode       (mode),
      .load_valid (load_valid),
      .load_ready (load_ready),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_visible (in_visible),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_hidden (out_hidden),
      .out_recon  (out_recon)
   );

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   function automatic int sat_add(input int acc, input int w);
      int s;
      s = acc + w;
      if (s > rbm_pkg::acc_max) s = rbm_pkg::acc_max;
      if (s < -rbm_pkg::acc_max) s = -rbm_pkg::acc_max;
      return s;
   endfunction

   // sigmoid rule, then threshold by mode
   function automatic logic fire(input int acc, input rbm_pkg::neuron_mode_e m,
                                 input logic [7:0] rnd);
      int p;
      p = (acc >>> rbm_pkg::sig_shift) + rbm_pkg::prob_half;
      if (p < 0) p = 0;
      if (p > 255) p = 255;
      if (m == rbm_pkg::mode_mean) return p > rbm_pkg::prob_half;
      return p > int'(rnd);
   endfunction

   function automatic logic [7:0] lfsr_step(input logic [7:0] l);
      if (l[0]) return (l >> 1) ^ rbm_pkg::lfsr_taps;
      return l >> 1;
   endfunction

   task automatic model_vector(input logic [15:0] vis, input rbm_pkg::neuron_mode_e m,
                               output logic [7:0] hid, output logic [15:0] rec);
      int acc;
      logic [7:0] h_bits;
      for (int h = 0; h < hid_dim; h++) begin
         acc = int'(mem_model[hbias_base + h]);
         for (int v = 0; v < vis_dim; v++) begin
            if (vis[v]) acc = sat_add(acc, int'(mem_model[v * hid_dim + h]));
         end
         h_bits[h] = fire(acc, m, fwd_lfsr);
         fwd_lfsr = lfsr_step(fwd_lfsr);
      end
      // reconstruction reads the same words transposed
      for (int v = 0; v < vis_dim; v++) begin
         acc = int'(mem_model[vbias_base + v]);
         for (int h = 0; h < hid_dim; h++) begin
            if (h_bits[h]) acc = sat_add(acc, int'(mem_model[v * hid_dim + h]));
         end
         rec[v] = fire(acc, m, bwd_lfsr);
         bwd_lfsr = lfsr_step(bwd_lfsr);
      end
      hid = h_bits;
   endtask

   task automatic check_bits(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic write_word(input int addr, input logic signed [11:0] data);
      int cycles;
      cycles = 0;
      load_valid = 1'b1;
      load_addr  = addr[7:0];
      load_data  = data;
      // load_ready follows load_valid combinationally, let it settle
      #5;
      while (!load_ready && cycles < wait_limit) begin
         @(negedge clock);
         #5;
         cycles++;
      end
      if (!load_ready) begin
         timeouts++;
         $display("load port never accepted the write to address %0d", addr);
      end else begin
         mem_model[addr] = data;
      end
      @(negedge clock);
      load_valid = 1'b0;
   endtask

   task automatic send_vector(input logic [15:0] vis);
      int cycles;
      cycles = 0;
      in_visible = vis;
      in_valid   = 1'b1;
      while (!in_ready && cycles < wait_limit) begin
         @(negedge clock);
         cycles++;
      end
      if (!in_ready) begin
         timeouts++;
         $display("input vector %h was never accepted", vis);
      end
      @(negedge clock);
      in_valid = 1'b0;
   endtask

   task automatic receive_and_check(input logic [7:0] exp_h, input logic [15:0] exp_r,
                                    input string what);
      int cycles;
      cycles = 0;
      while (!out_valid && cycles < wait_limit) begin
         @(negedge clock);
         cycles++;
      end
      if (!out_valid) begin
         timeouts++;
         $display("no output arrived for the %s vector", what);
      end else begin
         check_bits("out_hidden", {8'h00, out_hidden}, {8'h00, exp_h});
         check_bits("out_recon", out_recon, exp_r);
      end
      @(negedge clock);
   endtask

   task automatic run_vector(input logic [15:0] vis, input rbm_pkg::neuron_mode_e m,
                             input string what);
      logic [7:0]  eh;
      logic [15:0] er;
      mode = m;
      out_ready = 1'b1;
      model_vector(vis, m, eh, er);
      send_vector(vis);
      receive_and_check(eh, er, what);
   endtask

   task automatic test_mean_step();
      integer rnd;
      for (int a = 0; a < word_count; a++) begin
         rnd = $random(seed);
         write_word(a, rnd[11:0]);
      end
      rnd = $random(seed);
      run_vector(rnd[15:0], rbm_pkg::mode_mean, "mean-field");
   endtask

   task automatic test_zero_input();
      run_vector(16'h0000, rbm_pkg::mode_mean, "all-zero");
   endtask

   task automatic test_saturation();
      logic [7:0]  eh;
      logic [15:0] er;
      write_word(hbias_base, 12'sd0);
      for (int v = 0; v < 5; v++) write_word(v * hid_dim, 12'sd2047);
      for (int v = 5; v < 9; v++) write_word(v * hid_dim, -12'sd2047);
      write_word(9 * hid_dim, 12'sd100);
      mode = rbm_pkg::mode_mean;
      out_ready = 1'b1;
      // hidden 0 clamps at +8191 after the fifth add
      model_vector(16'h03ff, rbm_pkg::mode_mean, eh, er);
      send_vector(16'h03ff);
      receive_and_check(eh, er, "saturation");
   endtask

   task automatic test_sample_mode();
      integer rnd;
      for (int n = 0; n < 3; n++) begin
         rnd = $random(seed);
         run_vector(rnd[15:0], rbm_pkg::mode_sample, "sample-mode");
      end
   endtask

   task automatic test_stream();
      integer      rnd;
      logic [15:0] vis [6];
      logic [7:0]  exp_h [6];
      logic [15:0] exp_r [6];
      logic [7:0]  prev_h;
      logic [15:0] prev_r;
      logic        prev_hold;
      int          received;
      int          cycles;
      mode = rbm_pkg::mode_sample;
      for (int n = 0; n < 6; n++) begin
         rnd = $random(seed);
         vis[n] = rnd[15:0];
         model_vector(vis[n], rbm_pkg::mode_sample, exp_h[n], exp_r[n]);
      end
      received  = 0;
      cycles    = 0;
      prev_hold = 1'b0;
      prev_h    = '0;
      prev_r    = '0;
      fork
         for (int n = 0; n < 6; n++) send_vector(vis[n]);
         begin
            while (received < 6 && cycles < stream_limit) begin
               // a stalled output must not move
               if (prev_hold && (!out_valid || out_hidden !== prev_h || out_recon !== prev_r)) begin
                  errors++;
                  $display("output changed at %0t ns while stalled by out_ready", $time);
               end
               rnd = $random(seed);
               out_ready = rnd[0];
               if (out_valid && out_ready) begin
                  check_bits("out_hidden", {8'h00, out_hidden}, {8'h00, exp_h[received]});
                  check_bits("out_recon", out_recon, exp_r[received]);
                  received++;
               end
               prev_hold = out_valid && !out_ready;
               prev_h    = out_hidden;
               prev_r    = out_recon;
               @(negedge clock);
               cycles++;
            end
            if (received < 6) begin
               timeouts++;
               $display("only %0d of 6 streamed vectors came out", received);
            end
            out_ready = 1'b1;
         end
      join
   endtask

   initial begin
      reset      = 1'b1;
      mode       = rbm_pkg::mode_mean;
      load_valid = 1'b0;
      load_addr  = '0;
      load_data  = '0;
      in_valid   = 1'b0;
      in_visible = '0;
      out_ready  = 1'b1;
      fwd_lfsr   = fwd_seed;
      bwd_lfsr   = bwd_seed;
      repeat (2) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      @(negedge clock);
      check_bits("out_valid", {15'h0, out_valid}, 16'h0000);
      check_bits("in_ready", {15'h0, in_ready}, 16'h0001);
      check_bits("load_ready", {15'h0, load_ready}, 16'h0001);
      test_mean_step();
      test_zero_input();
      test_saturation();
      test_sample_mode();
      test_stream();
      repeat (4) @(negedge clock);
      $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
rtl/rbm_pkg.sv
rtl/weight_bus_if.sv
rtl/weight_store.sv
rtl/weight_arbiter.sv
rtl/neuron_unit.sv
rtl/rbm_layer.sv
rtl/rbm_gibbs_top.sv
bench/rbm_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module rbm_tb -o rbm_sim
./obj_dir/rbm_sim | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi
